// ==== Makefile ====
# Verilator build and run of the IMU path testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= imu_path_tb
FILELIST  ?= drone_imu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/drone_imu_pkg.sv ====
// Shared constants and types for the IMU data path.
// Imported by the interfaces, the RTL blocks and the testbench.
package drone_imu_pkg;

  localparam int IMU_VAL_W   = 16;           // Bits per sensor word
  localparam int NUM_AXES    = 3;
  localparam int AXIS_X      = 0;
  localparam int AXIS_Y      = 1;
  localparam int AXIS_Z      = 2;

  localparam logic [7:0] FRAME_SYNC = 8'hA5; // Marks the start of a frame
  localparam int FRAME_BYTES = 18;           // Payload bytes after the sync byte
  localparam int FRAME_BITS  = FRAME_BYTES * 8;
  localparam int FRAME_CNT_W = $clog2(FRAME_BYTES);

  localparam int VEL_SHIFT   = 4;            // Accel scaling before accumulation

  typedef logic signed [IMU_VAL_W-1:0] imu_word_t;
  typedef imu_word_t [NUM_AXES-1:0] imu_vec_t; // Index 0 is the x axis

  localparam imu_word_t IMU_WORD_MAX = 16'sh7FFF;
  localparam imu_word_t IMU_WORD_MIN = 16'sh8000;

  // Byte order on the wire puts rate x first, so rate sits at the low end
  typedef struct packed {
    imu_vec_t accel;
    imu_vec_t angle;
    imu_vec_t rate;
  } imu_frame_t;

  typedef enum logic [1:0] {
    IMU_SEL_DISABLE      = 2'b00,
    IMU_SEL_PASS_THROUGH = 2'b01
  } imu_sel_e;

  typedef enum logic [1:0] {
    FS_DISARMED = 2'd0,
    FS_ARMED    = 2'd1,
    FS_PASS     = 2'd2
  } flight_state_e;

  typedef enum logic [1:0] {
    DS_HUNT    = 2'd0,
    DS_PAYLOAD = 2'd1,
    DS_HOLD    = 2'd2
  } decode_state_e;

endpackage

// ==== common/imu_if.sv ====
// Internal links of the IMU path.
// imu_sample_if carries decoded frames with valid/ready,
// imu_state_if carries the integrated sample with valid only.
`timescale 1ns/100ps

interface imu_sample_if;
  import drone_imu_pkg::*;

  logic     valid;
  logic     ready;
  imu_vec_t rate;
  imu_vec_t angle;
  imu_vec_t accel;

  modport source (
    output valid, rate, angle, accel,
    input  ready
  );

  modport sink (
    input  valid, rate, angle, accel,
    output ready
  );
endinterface

interface imu_state_if;
  import drone_imu_pkg::*;

  logic     valid;  // One cycle per sample
  imu_vec_t rate;
  imu_vec_t angle;
  imu_vec_t accel;
  imu_vec_t vel;

  modport source (
    output valid, rate, angle, accel, vel
  );

  modport sink (
    input  valid, rate, angle, accel, vel
  );
endinterface

// ==== drone_imu.f ====
common/drone_imu_pkg.sv
common/imu_if.sv
imu_decoder/imu_frame_decoder.sv
source/velocity_integrator.sv
source/flight_mode_ctrl.sv
source/imu_data_buffer.sv
source/imu_path_top.sv
tb/imu_path_assertions.sv
tb/imu_path_checker.sv
tb/imu_path_tb.sv

// ==== imu_decoder/imu_frame_decoder.sv ====
// Turns the sensor byte stream into IMU frames.
// Hunts for the sync byte, shifts in 18 payload bytes, then holds the
// frame on the sample link until the integrator takes it.
`timescale 1ns/100ps

module imu_frame_decoder (
  input  logic                us_clk,
  input  logic                arst_n,
  input  logic [7:0]          byte_data,
  input  logic                byte_valid,
  output logic                byte_ready,
  imu_sample_if.source        sample_out
);
  import drone_imu_pkg::*;

  decode_state_e          state_q;
  logic [FRAME_CNT_W-1:0] byte_cnt;
  logic [FRAME_BITS-1:0]  frame_q;
  logic                   byte_hs;
  logic                   last_byte;
  imu_frame_t             frame;

  assign byte_ready = (state_q != DS_HOLD);    // Stall the source while holding
  assign byte_hs    = byte_valid & byte_ready;
  assign last_byte  = (byte_cnt == FRAME_CNT_W'(FRAME_BYTES - 1));

  always_ff @(posedge us_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= DS_HUNT;
      byte_cnt <= '0;
    end else begin
      case (state_q)
        DS_HUNT: begin
          byte_cnt <= '0;
          if (byte_hs && (byte_data == FRAME_SYNC)) begin
            state_q <= DS_PAYLOAD;
          end
        end
        DS_PAYLOAD: begin
          if (byte_hs) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (last_byte) begin
              state_q <= DS_HOLD;
            end
          end
        end
        DS_HOLD: begin
          if (sample_out.ready) begin            // Frame taken this edge
            state_q <= DS_HUNT;
          end
        end
        default: state_q <= DS_HUNT;
      endcase
    end
  end

  // New bytes enter at the top, so the first byte ends up in bits 7:0
  always_ff @(posedge us_clk) begin
    if (byte_hs && (state_q == DS_PAYLOAD)) begin
      frame_q <= {byte_data, frame_q[FRAME_BITS-1:8]};
    end
  end

  assign frame = imu_frame_t'(frame_q);

  assign sample_out.valid = (state_q == DS_HOLD);
  assign sample_out.rate  = frame.rate;
  assign sample_out.angle = frame.angle;
  assign sample_out.accel = frame.accel;

endmodule

// ==== source/flight_mode_ctrl.sv ====
// Flight mode FSM driven by the remote-control switches swa and swb.
// swa arms the craft, swb selects pass-through of the raw IMU data.
`timescale 1ns/100ps

module flight_mode_ctrl (
  input  logic                          us_clk,
  input  logic                          arst_n,
  input  logic                          swa,
  input  logic                          swb,
  output drone_imu_pkg::flight_state_e  flight_state,
  output drone_imu_pkg::imu_sel_e       imu_sel,
  output logic                          vel_clear
);
  import drone_imu_pkg::*;

  logic [1:0]    swa_sync;
  logic [1:0]    swb_sync;
  logic          swa_s;
  logic          swb_s;
  flight_state_e state_d;

  // Two-flop synchronizers for the asynchronous switches
  always_ff @(posedge us_clk or negedge arst_n) begin
    if (!arst_n) begin
      swa_sync <= '0;
      swb_sync <= '0;
    end else begin
      swa_sync <= {swa_sync[0], swa};
      swb_sync <= {swb_sync[0], swb};
    end
  end

  assign swa_s = swa_sync[1];
  assign swb_s = swb_sync[1];

  always_comb begin
    state_d = flight_state;
    case (flight_state)
      FS_DISARMED: if (swa_s && !swb_s) state_d = FS_ARMED;
      FS_ARMED:    if (swb_s)           state_d = FS_PASS;
      FS_PASS:     if (!swb_s)          state_d = FS_ARMED;
      default:                          state_d = FS_DISARMED;
    endcase
    if (!swa_s) begin
      state_d = FS_DISARMED;                 // Disarm wins from any state
    end
  end

  always_ff @(posedge us_clk or negedge arst_n) begin
    if (!arst_n) begin
      flight_state <= FS_DISARMED;
    end else begin
      flight_state <= state_d;
    end
  end

  assign imu_sel   = (flight_state == FS_PASS) ? IMU_SEL_PASS_THROUGH : IMU_SEL_DISABLE;
  assign vel_clear = (flight_state == FS_DISARMED);

endmodule

// ==== source/imu_data_buffer.sv ====
// Output register seen by the control loops.
// Captures each integrated sample and blanks rate and angle unless
// the flight mode selects pass-through.
`timescale 1ns/100ps

module imu_data_buffer (
  input  logic                      us_clk,
  input  logic                      arst_n,
  input  drone_imu_pkg::imu_sel_e   imu_sel,
  imu_state_if.sink                 state_in,
  output drone_imu_pkg::imu_word_t  rate_x_buff,
  output drone_imu_pkg::imu_word_t  rate_y_buff,
  output drone_imu_pkg::imu_word_t  rate_z_buff,
  output drone_imu_pkg::imu_word_t  angle_x_buff,
  output drone_imu_pkg::imu_word_t  angle_y_buff,
  output drone_imu_pkg::imu_word_t  angle_z_buff,
  output drone_imu_pkg::imu_word_t  lin_accel_x_buff,
  output drone_imu_pkg::imu_word_t  lin_accel_y_buff,
  output drone_imu_pkg::imu_word_t  lin_accel_z_buff,
  output drone_imu_pkg::imu_word_t  x_vel_buff,
  output drone_imu_pkg::imu_word_t  y_vel_buff,
  output drone_imu_pkg::imu_word_t  z_vel_buff,
  output logic                      sample_valid
);
  import drone_imu_pkg::*;

  imu_vec_t rate_q;
  imu_vec_t angle_q;
  imu_vec_t accel_q;
  imu_vec_t vel_q;

  always_ff @(posedge us_clk or negedge arst_n) begin
    if (!arst_n) begin
      rate_q       <= '0;
      angle_q      <= '0;
      accel_q      <= '0;
      vel_q        <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= state_in.valid;
      if (state_in.valid) begin
        accel_q <= state_in.accel;           // Accel and velocity always pass
        vel_q   <= state_in.vel;
        case (imu_sel)
          IMU_SEL_PASS_THROUGH: begin
            rate_q  <= state_in.rate;
            angle_q <= state_in.angle;
          end
          default: begin
            rate_q  <= '0;
            angle_q <= '0;
          end
        endcase
      end
    end
  end

  assign rate_x_buff      = rate_q[AXIS_X];
  assign rate_y_buff      = rate_q[AXIS_Y];
  assign rate_z_buff      = rate_q[AXIS_Z];
  assign angle_x_buff     = angle_q[AXIS_X];
  assign angle_y_buff     = angle_q[AXIS_Y];
  assign angle_z_buff     = angle_q[AXIS_Z];
  assign lin_accel_x_buff = accel_q[AXIS_X];
  assign lin_accel_y_buff = accel_q[AXIS_Y];
  assign lin_accel_z_buff = accel_q[AXIS_Z];
  assign x_vel_buff       = vel_q[AXIS_X];
  assign y_vel_buff       = vel_q[AXIS_Y];
  assign z_vel_buff       = vel_q[AXIS_Z];

endmodule

// ==== source/imu_path_top.sv ====
// Top level of the IMU data path.
// Byte stream in, buffered IMU words and flight state out.
`timescale 1ns/100ps

module imu_path_top (
  input  logic                          us_clk,
  input  logic                          arst_n,
  input  logic [7:0]                    byte_data,
  input  logic                          byte_valid,
  output logic                          byte_ready,
  input  logic                          swa,
  input  logic                          swb,
  output drone_imu_pkg::imu_word_t      rate_x_buff,
  output drone_imu_pkg::imu_word_t      rate_y_buff,
  output drone_imu_pkg::imu_word_t      rate_z_buff,
  output drone_imu_pkg::imu_word_t      angle_x_buff,
  output drone_imu_pkg::imu_word_t      angle_y_buff,
  output drone_imu_pkg::imu_word_t      angle_z_buff,
  output drone_imu_pkg::imu_word_t      lin_accel_x_buff,
  output drone_imu_pkg::imu_word_t      lin_accel_y_buff,
  output drone_imu_pkg::imu_word_t      lin_accel_z_buff,
  output drone_imu_pkg::imu_word_t      x_vel_buff,
  output drone_imu_pkg::imu_word_t      y_vel_buff,
  output drone_imu_pkg::imu_word_t      z_vel_buff,
  output logic                          sample_valid,
  output drone_imu_pkg::flight_state_e  flight_state
);
  import drone_imu_pkg::*;

  imu_sel_e imu_sel;
  logic     vel_clear;

  imu_sample_if sample_link ();              // Decoder to integrator
  imu_state_if  state_link ();               // Integrator to buffer

  imu_frame_decoder u_decoder (
    .us_clk     (us_clk),
    .arst_n     (arst_n),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready),
    .sample_out (sample_link)
  );

  velocity_integrator u_integrator (
    .us_clk    (us_clk),
    .arst_n    (arst_n),
    .vel_clear (vel_clear),
    .sample_in (sample_link),
    .state_out (state_link)
  );

  flight_mode_ctrl u_flight_mode (
    .us_clk       (us_clk),
    .arst_n       (arst_n),
    .swa          (swa),
    .swb          (swb),
    .flight_state (flight_state),
    .imu_sel      (imu_sel),
    .vel_clear    (vel_clear)
  );

  imu_data_buffer u_buffer (
    .us_clk           (us_clk),
    .arst_n           (arst_n),
    .imu_sel          (imu_sel),
    .state_in         (state_link),
    .rate_x_buff      (rate_x_buff),
    .rate_y_buff      (rate_y_buff),
    .rate_z_buff      (rate_z_buff),
    .angle_x_buff     (angle_x_buff),
    .angle_y_buff     (angle_y_buff),
    .angle_z_buff     (angle_z_buff),
    .lin_accel_x_buff (lin_accel_x_buff),
    .lin_accel_y_buff (lin_accel_y_buff),
    .lin_accel_z_buff (lin_accel_z_buff),
    .x_vel_buff       (x_vel_buff),
    .y_vel_buff       (y_vel_buff),
    .z_vel_buff       (z_vel_buff),
    .sample_valid     (sample_valid)
  );

endmodule

// ==== source/velocity_integrator.sv ====
// Integrates linear acceleration into a velocity per axis.
// Each accepted frame adds accel >>> VEL_SHIFT with signed saturation,
// then the frame and the new velocity go out for one cycle.
`timescale 1ns/100ps

module velocity_integrator (
  input  logic          us_clk,
  input  logic          arst_n,
  input  logic          vel_clear,
  imu_sample_if.sink    sample_in,
  imu_state_if.source   state_out
);
  import drone_imu_pkg::*;

  logic     out_valid_q;
  logic     take;
  imu_vec_t rate_q;
  imu_vec_t angle_q;
  imu_vec_t accel_q;
  imu_vec_t vel_q;

  function automatic imu_word_t sat_add(imu_word_t vel, imu_word_t accel);
    logic signed [IMU_VAL_W:0] sum;
    sum = vel + (accel >>> VEL_SHIFT);       // One guard bit catches overflow
    if (sum[IMU_VAL_W] != sum[IMU_VAL_W-1]) begin
      return sum[IMU_VAL_W] ? IMU_WORD_MIN : IMU_WORD_MAX;
    end
    return sum[IMU_VAL_W-1:0];
  endfunction

  assign sample_in.ready = ~out_valid_q;     // Slot empties after each pulse
  assign take            = sample_in.valid & sample_in.ready;

  always_ff @(posedge us_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid_q <= 1'b0;
      vel_q       <= '0;
    end else begin
      out_valid_q <= take;
      if (vel_clear) begin
        vel_q <= '0;                         // Disarmed, no accumulation
      end else if (take) begin
        for (int i = 0; i < NUM_AXES; i++) begin
          vel_q[i] <= sat_add(vel_q[i], sample_in.accel[i]);
        end
      end
    end
  end

  always_ff @(posedge us_clk) begin
    if (take) begin
      rate_q  <= sample_in.rate;
      angle_q <= sample_in.angle;
      accel_q <= sample_in.accel;
    end
  end

  assign state_out.valid = out_valid_q;
  assign state_out.rate  = rate_q;
  assign state_out.angle = angle_q;
  assign state_out.accel = accel_q;
  assign state_out.vel   = vel_q;

endmodule

// ==== tb/imu_path_assertions.sv ====
// Protocol checks on the frame decoder, attached by bind.
// Covers the sample link hold rule, byte back-pressure and the reset state.
`timescale 1ns/100ps

module imu_path_assertions (
  input logic                          us_clk,
  input logic                          arst_n,
  input drone_imu_pkg::decode_state_e  state_q,
  input logic                          byte_ready,
  input logic                          valid,
  input logic                          ready,
  input drone_imu_pkg::imu_vec_t       rate,
  input drone_imu_pkg::imu_vec_t       angle,
  input drone_imu_pkg::imu_vec_t       accel
);
  import drone_imu_pkg::*;

  int fail_count = 0;  // Read by the testbench at the end of the run

  a_offer_stable: assert property (@(posedge us_clk) disable iff (!arst_n)
    valid && !ready |=> valid && $stable(rate) && $stable(angle) && $stable(accel))
    else begin
      $error("sample link dropped valid or changed data before ready");
      fail_count++;
    end

  // Stalled while holding, released only once the frame is taken
  a_hold_stalls: assert property (@(posedge us_clk) disable iff (!arst_n)
    state_q == DS_HOLD |=> !$past(byte_ready) && (byte_ready == $past(ready)))
    else begin
      $error("byte_ready not held low until the held frame was taken");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge us_clk) $rose(arst_n) |-> !valid && byte_ready)
    else begin
      $error("decoder not idle after reset");
      fail_count++;
    end

endmodule

// ==== tb/imu_path_checker.sv ====
// Scoreboard for the IMU path testbench.
// Rebuilds frames from the byte handshakes, predicts the twelve buffered
// words and compares them at every sample_valid. Keeps per-test counts.
`timescale 1ns/100ps

module imu_path_checker (
  input logic                          us_clk,
  input logic                          arst_n,
  input logic [7:0]                    byte_data,
  input logic                          byte_valid,
  input logic                          byte_ready,
  input drone_imu_pkg::flight_state_e  flight_state,
  input drone_imu_pkg::imu_word_t      rate_x_buff,
  input drone_imu_pkg::imu_word_t      rate_y_buff,
  input drone_imu_pkg::imu_word_t      rate_z_buff,
  input drone_imu_pkg::imu_word_t      angle_x_buff,
  input drone_imu_pkg::imu_word_t      angle_y_buff,
  input drone_imu_pkg::imu_word_t      angle_z_buff,
  input drone_imu_pkg::imu_word_t      lin_accel_x_buff,
  input drone_imu_pkg::imu_word_t      lin_accel_y_buff,
  input drone_imu_pkg::imu_word_t      lin_accel_z_buff,
  input drone_imu_pkg::imu_word_t      x_vel_buff,
  input drone_imu_pkg::imu_word_t      y_vel_buff,
  input drone_imu_pkg::imu_word_t      z_vel_buff,
  input logic                          sample_valid
);
  import drone_imu_pkg::*;

  typedef struct packed {
    imu_vec_t rate;
    imu_vec_t angle;
    imu_vec_t accel;
    imu_vec_t vel;
  } expect_t;

  expect_t    exp_q[$];                  // Frames decoded but not yet seen at the output
  imu_vec_t   model_vel;
  logic [7:0] payload [FRAME_BYTES];
  int         pay_cnt;
  logic       in_frame;
  string      test_name = "none";
  int         test_errors;
  int         test_samples;
  int         total_checks;
  int         total_errors;
  int         tests_run;
  int         tests_failed;

  // Velocity and selection rules applied to one frame
  function automatic expect_t predict_outputs(imu_vec_t rate, imu_vec_t angle,
                                              imu_vec_t accel, imu_vec_t vel_in,
                                              flight_state_e fs);
    expect_t e;
    int      sum;
    e.rate  = '0;
    e.angle = '0;
    e.accel = accel;
    if (fs == FS_PASS) begin
      e.rate  = rate;
      e.angle = angle;
    end
    for (int i = 0; i < NUM_AXES; i++) begin
      sum = int'($signed(vel_in[i])) + (int'($signed(accel[i])) >>> VEL_SHIFT);
      if (sum > 32767)
        sum = 32767;
      if (sum < -32768)
        sum = -32768;
      e.vel[i] = (fs == FS_DISARMED) ? '0 : imu_word_t'(sum);
    end
    return e;
  endfunction

  task automatic push_frame();
    imu_vec_t r;
    imu_vec_t a;
    imu_vec_t ac;
    expect_t  e;
    for (int k = 0; k < NUM_AXES; k++) begin   // Low byte first on the wire
      r[k]  = {payload[2*k+1], payload[2*k]};
      a[k]  = {payload[2*k+7], payload[2*k+6]};
      ac[k] = {payload[2*k+13], payload[2*k+12]};
    end
    e = predict_outputs(r, a, ac, model_vel, flight_state);
    model_vel = e.vel;
    exp_q.push_back(e);
  endtask

  task automatic report_failure(string msg);
    $display("Failure in test %s: %s", test_name, msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic check_word(string name, imu_word_t exp, imu_word_t act);
    total_checks++;
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %0d, actual %0d", test_name, name, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic check_all(expect_t e);
    check_word("rate_x", e.rate[AXIS_X], rate_x_buff);
    check_word("rate_y", e.rate[AXIS_Y], rate_y_buff);
    check_word("rate_z", e.rate[AXIS_Z], rate_z_buff);
    check_word("angle_x", e.angle[AXIS_X], angle_x_buff);
    check_word("angle_y", e.angle[AXIS_Y], angle_y_buff);
    check_word("angle_z", e.angle[AXIS_Z], angle_z_buff);
    check_word("accel_x", e.accel[AXIS_X], lin_accel_x_buff);
    check_word("accel_y", e.accel[AXIS_Y], lin_accel_y_buff);
    check_word("accel_z", e.accel[AXIS_Z], lin_accel_z_buff);
    check_word("vel_x", e.vel[AXIS_X], x_vel_buff);
    check_word("vel_y", e.vel[AXIS_Y], y_vel_buff);
    check_word("vel_z", e.vel[AXIS_Z], z_vel_buff);
  endtask

  always @(posedge us_clk) begin
    if (!arst_n) begin
      in_frame  = 1'b0;
      pay_cnt   = 0;
      model_vel = '0;
    end else begin
      if (flight_state == FS_DISARMED)
        model_vel = '0;                      // Velocity held cleared while disarmed
      if (byte_valid && byte_ready) begin
        if (!in_frame) begin
          in_frame = (byte_data == FRAME_SYNC);
          pay_cnt  = 0;
        end else begin
          payload[pay_cnt] = byte_data;
          pay_cnt++;
          if (pay_cnt == FRAME_BYTES) begin
            in_frame = 1'b0;
            push_frame();
          end
        end
      end
      if (sample_valid) begin
        test_samples++;
        if (exp_q.size() == 0)
          report_failure("sample_valid pulsed with no frame pending");
        else
          check_all(exp_q.pop_front());
      end
    end
  end

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic begin_test(string name);
    test_name    = name;
    test_errors  = 0;
    test_samples = 0;
  endtask

  task automatic check_reset_state();
    check_all('0);
    if (sample_valid !== 1'b0)
      report_failure("sample_valid high after reset");
    if (byte_ready !== 1'b1)
      report_failure("byte_ready low after reset");
  endtask

  task automatic expect_state(flight_state_e exp);
    total_checks++;
    if (flight_state !== exp) begin
      $display("** Error [%s] flight_state: expected %s, actual %s",
               test_name, exp.name(), flight_state.name());
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic end_test(int frames);
    total_checks++;
    if (test_samples != frames) begin
      $display("** Error [%s] sample_valid pulses: expected %0d, actual %0d",
               test_name, frames, test_samples);
      test_errors++;
      total_errors++;
    end
    if (exp_q.size() != 0)
      report_failure($sformatf("%0d frames never reached the output", exp_q.size()));
    exp_q.delete();
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("Test %-15s %s  samples %0d  errors %0d", test_name,
             (test_errors == 0) ? "ok" : "FAILED", test_samples, test_errors);
  endtask

endmodule

// ==== tb/imu_path_tb.sv ====
// Top-level testbench of the IMU data path.
// Drives byte frames and switch settings on the falling edge, the checker
// compares every buffered sample. Ends with a one-line summary.
`timescale 1ns/100ps

module imu_path_tb;
  import drone_imu_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int TOTAL_FRAMES = 3 + 2 + 3 + 65 + 16;     // Sum over the five tests
  localparam int CYCLE_LIMIT  = TOTAL_FRAMES * 40 + 500;

  logic          us_clk;
  logic          arst_n;
  logic [7:0]    byte_data;
  logic          byte_valid;
  logic          byte_ready;
  logic          swa;
  logic          swb;
  imu_word_t     rate_x_buff;
  imu_word_t     rate_y_buff;
  imu_word_t     rate_z_buff;
  imu_word_t     angle_x_buff;
  imu_word_t     angle_y_buff;
  imu_word_t     angle_z_buff;
  imu_word_t     lin_accel_x_buff;
  imu_word_t     lin_accel_y_buff;
  imu_word_t     lin_accel_z_buff;
  imu_word_t     x_vel_buff;
  imu_word_t     y_vel_buff;
  imu_word_t     z_vel_buff;
  logic          sample_valid;
  flight_state_e flight_state;
  integer        seed;
  int            cycle_count;

  bind imu_frame_decoder imu_path_assertions u_assert (
    .us_clk (us_clk), .arst_n (arst_n), .state_q (state_q), .byte_ready (byte_ready),
    .valid (sample_out.valid), .ready (sample_out.ready), .rate (sample_out.rate),
    .angle (sample_out.angle), .accel (sample_out.accel)
  );

  imu_path_top uut (.*);
  imu_path_checker chk (.*);

  initial begin
    us_clk = 1'b0;
    forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge us_clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  function automatic imu_vec_t rand_vec();
    imu_vec_t v;
    for (int i = 0; i < NUM_AXES; i++) begin
      v[i] = imu_word_t'($random(seed));
    end
    return v;
  endfunction

  // Offers one byte, optionally after a random idle gap, until it is taken
  task automatic send_byte(logic [7:0] b, bit gaps);
    int waited;
    if (gaps && (($random(seed) & 7) == 0)) begin
      byte_valid = 1'b0;
      repeat (1 + ($random(seed) & 3)) @(negedge us_clk);
    end
    byte_data  = b;
    byte_valid = 1'b1;
    waited     = 0;
    while (!byte_ready && waited < 50) begin
      @(negedge us_clk);
      waited++;
    end
    if (!byte_ready)
      chk.report_failure("byte_ready stayed low, byte source stalled");
    @(negedge us_clk);
    byte_valid = 1'b0;
  endtask

  task automatic send_frame(imu_vec_t rate, imu_vec_t angle, imu_vec_t accel, bit gaps);
    imu_word_t w;
    send_byte(FRAME_SYNC, gaps);
    for (int k = 0; k < 3 * NUM_AXES; k++) begin
      if (k < NUM_AXES)
        w = rate[k];
      else if (k < 2 * NUM_AXES)
        w = angle[k - NUM_AXES];
      else
        w = accel[k - 2 * NUM_AXES];
      send_byte(w[7:0], gaps);
      send_byte(w[15:8], gaps);
    end
  endtask

  task automatic drain_frames();
    int waited;
    waited = 0;
    while (chk.pending() != 0 && waited < 100) begin
      @(negedge us_clk);
      waited++;
    end
    repeat (4) @(negedge us_clk);
  endtask

  task automatic set_switches(logic a, logic b, flight_state_e exp);
    drain_frames();                          // Switches move only with no frame in flight
    swa = a;
    swb = b;
    repeat (5) @(negedge us_clk);
    chk.expect_state(exp);
  endtask

  task automatic finish_test(int frames);
    drain_frames();
    chk.end_test(frames);
  endtask

  initial begin
    logic [7:0] junk;
    seed       = 2511;
    arst_n     = 1'b0;
    byte_data  = 8'h00;
    byte_valid = 1'b0;
    swa        = 1'b0;
    swb        = 1'b0;
    repeat (RESET_CYCLES) @(negedge us_clk);
    arst_n = 1'b1;
    @(negedge us_clk);

    chk.begin_test("reset_disarmed");
    chk.check_reset_state();
    chk.expect_state(FS_DISARMED);
    repeat (3) send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b0);
    finish_test(3);

    chk.begin_test("sync_hunt");
    for (int i = 0; i < 10; i++) begin
      junk = 8'($random(seed));
      if (junk == FRAME_SYNC)
        junk = 8'h00;
      send_byte(junk, 1'b0);
    end
    repeat (10) @(negedge us_clk);           // Any sample_valid here is unexpected
    repeat (2) send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b0);
    finish_test(2);

    chk.begin_test("pass_through");
    set_switches(1'b1, 1'b0, FS_ARMED);
    set_switches(1'b1, 1'b1, FS_PASS);
    repeat (3) send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b0);
    finish_test(3);

    chk.begin_test("velocity");
    set_switches(1'b1, 1'b0, FS_ARMED);
    repeat (6) send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b0);
    repeat (24) send_frame(rand_vec(), rand_vec(), {NUM_AXES{16'sh7FFF}}, 1'b0);
    repeat (34) send_frame(rand_vec(), rand_vec(), {NUM_AXES{16'sh8000}}, 1'b0);
    set_switches(1'b0, 1'b0, FS_DISARMED);
    send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b0);
    finish_test(65);

    chk.begin_test("stream_stall");
    set_switches(1'b1, 1'b0, FS_ARMED);
    set_switches(1'b1, 1'b1, FS_PASS);
    repeat (16) send_frame(rand_vec(), rand_vec(), rand_vec(), 1'b1);
    finish_test(16);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             chk.tests_run, chk.tests_failed, chk.total_checks, chk.total_errors,
             uut.u_decoder.u_assert.fail_count);
    if (chk.total_errors == 0 && uut.u_decoder.u_assert.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
